/* src.f */
src/ddr_tg_pkg.sv
src/ddr_tg_regs.sv
src/ddr_tg_seq.sv
src/ddr_tg_check.sv
src/ddr_tg_top.sv
verification/ddr_app_model.sv
verification/ddr_tg_tb.sv

/* verification/ddr_tg_tb.sv */
// Table-driven testbench for the DDR4 traffic tester top level.
// Each table row configures the tester over the register port, runs one
// write and read pass against the controller model and checks the results,
// the model memory and the command count.

`timescale 1ns/10ps
`default_nettype none

module ddr_tg_tb;

  localparam int unsigned DATA_W = 128;
  localparam int unsigned N_ROWS = 9;
  localparam logic [2:0] REG_CTRL      = 3'd0;
  localparam logic [2:0] REG_BASE      = 3'd1;
  localparam logic [2:0] REG_WORDS     = 3'd2;
  localparam logic [2:0] REG_STATUS    = 3'd3;
  localparam logic [2:0] REG_ERR_CNT   = 3'd4;
  localparam logic [2:0] REG_FIRST_ERR = 3'd5;

  typedef struct packed {
    logic [27:0]           base;
    logic [15:0]           words;
    ddr_tg_pkg::pattern_e  pattern;
    logic                  fault_en;
    logic [27:0]           fault_addr;
    logic [6:0]            stall;
    logic [15:0]           exp_err;
    logic [27:0]           exp_first;
  } test_row_t;

  test_row_t             rows [N_ROWS];
  logic                  clk;
  logic                  arst_n;
  logic                  calib;
  logic                  reg_we;
  logic [2:0]            reg_addr;
  logic [31:0]           reg_wdata;
  logic [31:0]           reg_rdata;
  logic                  app_en;
  ddr_tg_pkg::app_req_t  app_req;
  logic                  app_rdy;
  logic                  app_wdf_wren;
  logic [DATA_W-1:0]     app_wdf_data;
  logic                  app_wdf_rdy;
  logic                  rd_valid;
  logic [DATA_W-1:0]     rd_data;
  logic                  done;
  logic                  cmp_err;
  logic [6:0]            stall_pct;
  logic                  fault_en;
  logic [27:0]           fault_addr;
  logic [31:0]           cmd_cnt;
  logic                  proto_err;
  logic [31:0]           rdata;

  ddr_tg_top #(
    .DATA_W (DATA_W)
  ) i_dut (
    .c0_ddr4_clk          (clk),
    .arst_n_i             (arst_n),
    .calib_complete_i     (calib),
    .reg_we_i             (reg_we),
    .reg_addr_i           (reg_addr),
    .reg_wdata_i          (reg_wdata),
    .reg_rdata_o          (reg_rdata),
    .app_en_o             (app_en),
    .app_req_o            (app_req),
    .app_rdy_i            (app_rdy),
    .app_wdf_wren_o       (app_wdf_wren),
    .app_wdf_data_o       (app_wdf_data),
    .app_wdf_rdy_i        (app_wdf_rdy),
    .app_rd_data_valid_i  (rd_valid),
    .app_rd_data_i        (rd_data),
    .done_o               (done),
    .data_compare_error_o (cmp_err)
  );

  ddr_app_model #(
    .DATA_W (DATA_W)
  ) i_model (
    .c0_ddr4_clk         (clk),
    .arst_n_i            (arst_n),
    .app_en_i            (app_en),
    .app_req_i           (app_req),
    .app_rdy_o           (app_rdy),
    .app_wdf_wren_i      (app_wdf_wren),
    .app_wdf_data_i      (app_wdf_data),
    .app_wdf_rdy_o       (app_wdf_rdy),
    .app_rd_data_valid_o (rd_valid),
    .app_rd_data_o       (rd_data),
    .stall_pct_i         (stall_pct),
    .fault_en_i          (fault_en),
    .fault_addr_i        (fault_addr),
    .cmd_cnt_o           (cmd_cnt),
    .proto_err_o         (proto_err)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ************************************************************************
  // Helpers
  // ************************************************************************
  // Lane rule: address, its inverse, 5/A by address bit 3, or a walking one
  function automatic logic [63:0] expected_lane(input logic [27:0] addr,
                                                input ddr_tg_pkg::pattern_e pat);
    logic [63:0] lane;
    case (pat)
      ddr_tg_pkg::PAT_ADDR:     lane = {36'd0, addr};
      ddr_tg_pkg::PAT_INV_ADDR: lane = ~{36'd0, addr};
      ddr_tg_pkg::PAT_CHECKER:  lane = addr[3] ? 64'hAAAA_AAAA_AAAA_AAAA : 64'h5555_5555_5555_5555;
      default:                  lane = 64'd1 << ((addr / 8) % 64);
    endcase
    return lane;
  endfunction

  task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
    assert (actual === expected) else begin
      $display("FAILED at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
    @(negedge clk);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_we    = 1'b0;
  endtask

  task automatic read_reg(input logic [2:0] addr, output logic [31:0] data);
    @(negedge clk);
    reg_addr = addr;
    #10;
    data = reg_rdata;
  endtask

  task automatic run_row(input test_row_t row);
    logic [31:0]       cmd_start;
    logic [27:0]       addr;
    logic [DATA_W-1:0] exp_word;
    @(negedge clk);
    stall_pct  = row.stall;
    fault_en   = row.fault_en;
    fault_addr = row.fault_addr;
    cmd_start  = cmd_cnt;
    write_reg(REG_BASE, {4'd0, row.base});
    write_reg(REG_WORDS, {16'd0, row.words});
    write_reg(REG_CTRL, {29'd0, row.pattern, 1'b1});
    read_reg(REG_STATUS, rdata);
    if (row.words != 16'd0) begin
      check_value("STATUS.running", 1'b1, rdata[0]);
      // Neither a new word count nor a start may touch a running test
      write_reg(REG_WORDS, {16'd0, row.words + 16'd5});
      write_reg(REG_CTRL, {29'd0, row.pattern, 1'b1});
      read_reg(REG_WORDS, rdata);
      check_value("WORDS", row.words, rdata);
    end
    while (done !== 1'b1) begin
      @(negedge clk);
    end
    read_reg(REG_STATUS, rdata);
    check_value("STATUS", 32'd2, rdata);
    read_reg(REG_ERR_CNT, rdata);
    check_value("ERR_CNT", row.exp_err, rdata);
    read_reg(REG_FIRST_ERR, rdata);
    check_value("FIRST_ERR", row.exp_first, rdata);
    check_value("data_compare_error_o", row.exp_err != 16'd0, cmp_err);
    check_value("model command count", 2 * row.words, cmd_cnt - cmd_start);
    for (int i = 0; i < row.words; i++) begin
      addr     = row.base + 28'(i * 8);
      exp_word = {(DATA_W / 64){expected_lane(addr, row.pattern)}};
      check_value($sformatf("model mem[%0h]", addr), exp_word, i_model.mem[addr[12:3]]);
    end
    assert (proto_err === 1'b0) else begin
      $display("Request or write data changed while stalled, seen by %0t ns", $time);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  // ************************************************************************
  // Main sequence
  // ************************************************************************
  initial begin
    rows[0] = '{28'h100, 16'd16, ddr_tg_pkg::PAT_ADDR,     1'b0, 28'h0,   7'd0,  16'd0, 28'h0};
    rows[1] = '{28'h400, 16'd12, ddr_tg_pkg::PAT_INV_ADDR, 1'b0, 28'h0,   7'd0,  16'd0, 28'h0};
    rows[2] = '{28'h080, 16'd20, ddr_tg_pkg::PAT_CHECKER,  1'b0, 28'h0,   7'd30, 16'd0, 28'h0};
    rows[3] = '{28'h800, 16'd70, ddr_tg_pkg::PAT_WALK1,    1'b0, 28'h0,   7'd0,  16'd0, 28'h0};
    rows[4] = '{28'h200, 16'd16, ddr_tg_pkg::PAT_ADDR,     1'b1, 28'h238, 7'd0,  16'd1, 28'h238};
    // Fault address just past the range
    rows[5] = '{28'h200, 16'd16, ddr_tg_pkg::PAT_CHECKER,  1'b1, 28'h280, 7'd0,  16'd0, 28'h0};
    rows[6] = '{28'h100, 16'd32, ddr_tg_pkg::PAT_WALK1,    1'b1, 28'h1F8, 7'd75, 16'd1, 28'h1F8};
    rows[7] = '{28'h100, 16'd32, ddr_tg_pkg::PAT_WALK1,    1'b1, 28'h1F8, 7'd0,  16'd1, 28'h1F8};
    rows[8] = '{28'h040, 16'd0,  ddr_tg_pkg::PAT_ADDR,     1'b0, 28'h0,   7'd0,  16'd0, 28'h0};
    arst_n     = 1'b0;
    calib      = 1'b0;
    reg_we     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    stall_pct  = '0;
    fault_en   = 1'b0;
    fault_addr = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    check_value("done_o", 1'b0, done);
    check_value("data_compare_error_o", 1'b0, cmp_err);
    check_value("app_en_o", 1'b0, app_en);
    check_value("app_wdf_wren_o", 1'b0, app_wdf_wren);
    read_reg(REG_STATUS, rdata);
    check_value("STATUS", 32'd0, rdata);
    // Start before calibration has completed
    write_reg(REG_WORDS, 32'd4);
    write_reg(REG_CTRL, 32'd1);
    read_reg(REG_STATUS, rdata);
    check_value("STATUS.running", 1'b0, rdata[0]);
    repeat (4) @(negedge clk);
    check_value("model command count", 32'd0, cmd_cnt);
    calib = 1'b1;
    for (int r = 0; r < N_ROWS; r++) begin
      run_row(rows[r]);
    end
    $display("Testbench passed");
    $finish;
  end

  // Watchdog sized from the table
  initial begin
    int limit;
    limit = 0;
    @(posedge arst_n);
    for (int r = 0; r < N_ROWS; r++) begin
      limit = limit + rows[r].words * 40 + 200;
    end
    repeat (limit) @(posedge clk);
    $display("Timeout: tests did not finish within %0d cycles", limit);
    $display("Testbench failed");
    $fatal(1);
  end

endmodule

`default_nettype wire

/* verification/ddr_app_model.sv */
// Behavioral stand-in for the DDR4 controller application interface.
// Random ready stalls, in-order read returns after 1 to 8 cycles, and an
// optional single-bit fault on the word read at one address.
// Also flags a request or write data that changes while it is stalled.

`timescale 1ns/10ps
`default_nettype none

module ddr_app_model #(
  parameter int unsigned DATA_W = 128
) (
  input  wire                   c0_ddr4_clk,
  input  wire                   arst_n_i,
  input  wire                   app_en_i,
  input  ddr_tg_pkg::app_req_t  app_req_i,
  output logic                  app_rdy_o,
  input  wire                   app_wdf_wren_i,
  input  wire [DATA_W-1:0]      app_wdf_data_i,
  output logic                  app_wdf_rdy_o,
  output logic                  app_rd_data_valid_o,
  output logic [DATA_W-1:0]     app_rd_data_o,
  input  wire [6:0]             stall_pct_i,
  input  wire                   fault_en_i,
  input  wire [27:0]            fault_addr_i,
  output logic [31:0]           cmd_cnt_o,
  output logic                  proto_err_o
);

  // Word memory, indexed by the burst part of the address
  logic [DATA_W-1:0]    mem [0:1023];
  logic [27:0]          wr_addr_q [$];
  logic [DATA_W-1:0]    wr_data_q [$];
  logic [27:0]          rd_addr_q [$];
  int                   rd_due_q [$];
  int                   cycle;
  int                   last_due;
  int                   due;
  integer               seed;
  logic                 cmd_pend;
  logic                 data_pend;
  ddr_tg_pkg::app_req_t req_hold;
  logic [DATA_W-1:0]    data_hold;
  logic [27:0]          rd_addr;
  logic [DATA_W-1:0]    rd_word;

  initial begin
    seed                = 32'h2a8f17eb;
    app_rdy_o           = 1'b0;
    app_wdf_rdy_o       = 1'b0;
    app_rd_data_valid_o = 1'b0;
    app_rd_data_o       = '0;
    cmd_cnt_o           = '0;
    proto_err_o         = 1'b0;
    cycle               = 0;
    last_due            = 0;
    cmd_pend            = 1'b0;
    data_pend           = 1'b0;
  end

  // ************************************************************************
  // Accept commands and write data on the rising edge
  // ************************************************************************
  always @(posedge c0_ddr4_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_addr_q.delete();
      wr_data_q.delete();
      rd_addr_q.delete();
      rd_due_q.delete();
      cmd_pend  = 1'b0;
      data_pend = 1'b0;
    end else begin
      cycle = cycle + 1;
      // Anything offered but stalled must be offered again unchanged
      if (cmd_pend && (!app_en_i || (app_req_i !== req_hold))) begin
        proto_err_o = 1'b1;
      end
      if (data_pend && (!app_wdf_wren_i || (app_wdf_data_i !== data_hold))) begin
        proto_err_o = 1'b1;
      end
      cmd_pend  = app_en_i && !app_rdy_o;
      req_hold  = app_req_i;
      data_pend = app_wdf_wren_i && !app_wdf_rdy_o;
      data_hold = app_wdf_data_i;
      if (app_en_i && app_rdy_o) begin
        cmd_cnt_o = cmd_cnt_o + 1;
        if (app_req_i.cmd == ddr_tg_pkg::APP_CMD_WRITE) begin
          wr_addr_q.push_back(app_req_i.addr);
        end else begin
          due = cycle + 1 + ({$random(seed)} % 8);
          if (due <= last_due) begin
            due = last_due + 1;
          end
          last_due = due;
          rd_addr_q.push_back(app_req_i.addr);
          rd_due_q.push_back(due);
        end
      end
      if (app_wdf_wren_i && app_wdf_rdy_o) begin
        wr_data_q.push_back(app_wdf_data_i);
      end
      // Pair command and data in order of arrival
      while ((wr_addr_q.size() > 0) && (wr_data_q.size() > 0)) begin
        rd_addr = wr_addr_q.pop_front();
        mem[rd_addr[12:3]] = wr_data_q.pop_front();
      end
    end
  end

  // ************************************************************************
  // Drive ready and read data on the falling edge
  // ************************************************************************
  always @(negedge c0_ddr4_clk) begin
    if (arst_n_i) begin
      app_rdy_o           = ({$random(seed)} % 100) >= stall_pct_i;
      app_wdf_rdy_o       = ({$random(seed)} % 100) >= stall_pct_i;
      app_rd_data_valid_o = 1'b0;
      if ((rd_due_q.size() > 0) && (rd_due_q[0] <= cycle)) begin
        rd_addr = rd_addr_q.pop_front();
        due     = rd_due_q.pop_front();
        rd_word = mem[rd_addr[12:3]];
        if (fault_en_i && (rd_addr == fault_addr_i)) begin
          rd_word[0] = ~rd_word[0];
        end
        app_rd_data_o       = rd_word;
        app_rd_data_valid_o = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/ddr_tg_top.sv */
// Top level of the DDR4 traffic tester. Connects the register block, the
// command sequencer and the read checker to the controller's application
// interface in the c0_ddr4_clk domain.

`timescale 1ns/10ps
`default_nettype none

module ddr_tg_top #(
  parameter int unsigned DATA_W = 64
) (
  input  wire                     c0_ddr4_clk,
  input  wire                     arst_n_i,
  input  wire                     calib_complete_i,
  // Register port
  input  wire                     reg_we_i,
  input  wire [2:0]               reg_addr_i,
  input  wire [31:0]              reg_wdata_i,
  output logic [31:0]             reg_rdata_o,
  // Application interface
  output logic                    app_en_o,
  output ddr_tg_pkg::app_req_t    app_req_o,
  input  wire                     app_rdy_i,
  output logic                    app_wdf_wren_o,
  output logic [DATA_W-1:0]       app_wdf_data_o,
  input  wire                     app_wdf_rdy_i,
  input  wire                     app_rd_data_valid_i,
  input  wire [DATA_W-1:0]        app_rd_data_i,
  // Test result
  output logic                    done_o,
  output logic                    data_compare_error_o
);

  ddr_tg_pkg::tg_cfg_t    cfg;
  ddr_tg_pkg::tg_status_t status;
  logic                   start;

  ddr_tg_regs i_regs (
    .c0_ddr4_clk      (c0_ddr4_clk),
    .arst_n_i         (arst_n_i),
    .calib_complete_i (calib_complete_i),
    .reg_we_i         (reg_we_i),
    .reg_addr_i       (reg_addr_i),
    .reg_wdata_i      (reg_wdata_i),
    .reg_rdata_o      (reg_rdata_o),
    .status_i         (status),
    .cfg_o            (cfg),
    .start_o          (start)
  );

  ddr_tg_seq #(
    .DATA_W (DATA_W)
  ) i_seq (
    .c0_ddr4_clk    (c0_ddr4_clk),
    .arst_n_i       (arst_n_i),
    .start_i        (start),
    .cfg_i          (cfg),
    .app_en_o       (app_en_o),
    .app_req_o      (app_req_o),
    .app_rdy_i      (app_rdy_i),
    .app_wdf_wren_o (app_wdf_wren_o),
    .app_wdf_data_o (app_wdf_data_o),
    .app_wdf_rdy_i  (app_wdf_rdy_i)
  );

  ddr_tg_check #(
    .DATA_W (DATA_W)
  ) i_check (
    .c0_ddr4_clk         (c0_ddr4_clk),
    .arst_n_i            (arst_n_i),
    .start_i             (start),
    .cfg_i               (cfg),
    .app_rd_data_valid_i (app_rd_data_valid_i),
    .app_rd_data_i       (app_rd_data_i),
    .status_o            (status)
  );

  assign done_o               = status.done;
  // Error count clears on start, so the flag holds until then
  assign data_compare_error_o = (status.err_cnt != 16'd0);

endmodule

`default_nettype wire

/* src/ddr_tg_check.sv */
// Read-data checker of the DDR4 traffic tester. Returns arrive in issue
// order, so the expected address is tracked locally and each word is
// compared against the pattern on arrival. Reports run status and errors.

`timescale 1ns/10ps
`default_nettype none

module ddr_tg_check #(
  parameter int unsigned DATA_W = 64
) (
  input  wire                     c0_ddr4_clk,
  input  wire                     arst_n_i,
  input  wire                     start_i,
  input  ddr_tg_pkg::tg_cfg_t     cfg_i,
  input  wire                     app_rd_data_valid_i,
  input  wire [DATA_W-1:0]        app_rd_data_i,
  output ddr_tg_pkg::tg_status_t  status_o
);

  localparam int unsigned LANES = DATA_W / ddr_tg_pkg::LANE_W;

  ddr_tg_pkg::tg_status_t              status_q;
  logic [ddr_tg_pkg::APP_ADDR_W-1:0]   exp_addr_q;
  logic [15:0]                         rem_q;
  logic [ddr_tg_pkg::LANE_W-1:0]       exp_lane;
  logic [DATA_W-1:0]                   exp_word;
  logic                                mismatch;

  assign exp_lane = ddr_tg_pkg::pattern_lane(exp_addr_q, cfg_i.pattern);
  assign exp_word = {LANES{exp_lane}};
  assign mismatch = app_rd_data_valid_i && (app_rd_data_i != exp_word);

  always_ff @(posedge c0_ddr4_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      status_q   <= '0;
      exp_addr_q <= '0;
      rem_q      <= '0;
    end else if (start_i) begin
      // Empty run completes straight away
      status_q.running        <= (cfg_i.words != 16'd0);
      status_q.done           <= (cfg_i.words == 16'd0);
      status_q.err_cnt        <= '0;
      status_q.first_err_addr <= '0;
      exp_addr_q              <= cfg_i.base_addr;
      rem_q                   <= cfg_i.words;
    end else if (status_q.running && app_rd_data_valid_i) begin
      exp_addr_q <= exp_addr_q + ddr_tg_pkg::ADDR_STEP;
      rem_q      <= rem_q - 16'd1;
      if (mismatch) begin
        if (status_q.err_cnt == 16'd0) begin
          status_q.first_err_addr <= exp_addr_q;
        end
        // Saturate rather than wrap back to a clean count
        if (status_q.err_cnt != 16'hFFFF) begin
          status_q.err_cnt <= status_q.err_cnt + 16'd1;
        end
      end
      if (rem_q == 16'd1) begin
        status_q.running <= 1'b0;
        status_q.done    <= 1'b1;
      end
    end
  end

  assign status_o = status_q;

  // No read may return outside a run launched by the sequencer
  a_valid_in_run : assert property (
    @(posedge c0_ddr4_clk) disable iff (!arst_n_i)
    app_rd_data_valid_i |-> status_q.running
  );

endmodule

`default_nettype wire

/* src/ddr_tg_seq.sv */
// Command sequencer of the DDR4 traffic tester. After a start pulse it
// writes the pattern over the configured range, then reads the range back,
// using the controller's native command and write-data handshakes.

`timescale 1ns/10ps
`default_nettype none

module ddr_tg_seq #(
  parameter int unsigned DATA_W = 64
) (
  input  wire                     c0_ddr4_clk,
  input  wire                     arst_n_i,
  input  wire                     start_i,
  input  ddr_tg_pkg::tg_cfg_t     cfg_i,
  output logic                    app_en_o,
  output ddr_tg_pkg::app_req_t    app_req_o,
  input  wire                     app_rdy_i,
  output logic                    app_wdf_wren_o,
  output logic [DATA_W-1:0]       app_wdf_data_o,
  input  wire                     app_wdf_rdy_i
);

  localparam int unsigned LANES = DATA_W / ddr_tg_pkg::LANE_W;

  ddr_tg_pkg::seq_state_e              state_q;
  logic [ddr_tg_pkg::APP_ADDR_W-1:0]   addr_q;
  logic [15:0]                         rem_q;
  logic                                cmd_done_q;
  logic                                data_done_q;
  logic                                cmd_acc;
  logic                                data_acc;
  logic                                word_done;
  logic                                last_word;
  logic [ddr_tg_pkg::LANE_W-1:0]       wr_lane;

  // ************************************************************************
  // Application interface drive
  // ************************************************************************
  always_comb begin
    app_en_o       = 1'b0;
    app_wdf_wren_o = 1'b0;
    case (state_q)
      ddr_tg_pkg::SEQ_WRITE: begin
        app_en_o       = !cmd_done_q;
        app_wdf_wren_o = !data_done_q;
      end
      ddr_tg_pkg::SEQ_READ:  app_en_o = 1'b1;
      default: begin
        app_en_o       = 1'b0;
        app_wdf_wren_o = 1'b0;
      end
    endcase
  end

  assign app_req_o.cmd  = (state_q == ddr_tg_pkg::SEQ_READ) ? ddr_tg_pkg::APP_CMD_READ
                                                             : ddr_tg_pkg::APP_CMD_WRITE;
  assign app_req_o.addr = addr_q;

  assign wr_lane        = ddr_tg_pkg::pattern_lane(addr_q, cfg_i.pattern);
  assign app_wdf_data_o = {LANES{wr_lane}};

  assign cmd_acc   = app_en_o && app_rdy_i;
  assign data_acc  = app_wdf_wren_o && app_wdf_rdy_i;
  // Command and data may be taken in either order
  assign word_done = (cmd_done_q || cmd_acc) && (data_done_q || data_acc);
  assign last_word = (rem_q == 16'd1);

  // ************************************************************************
  // Sequencer FSM
  // ************************************************************************
  always_ff @(posedge c0_ddr4_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= ddr_tg_pkg::SEQ_IDLE;
      addr_q      <= '0;
      rem_q       <= '0;
      cmd_done_q  <= 1'b0;
      data_done_q <= 1'b0;
    end else begin
      case (state_q)
        ddr_tg_pkg::SEQ_IDLE: begin
          // Zero words leaves the sequencer idle
          if (start_i && (cfg_i.words != 16'd0)) begin
            state_q     <= ddr_tg_pkg::SEQ_WRITE;
            addr_q      <= cfg_i.base_addr;
            rem_q       <= cfg_i.words;
            cmd_done_q  <= 1'b0;
            data_done_q <= 1'b0;
          end
        end

        ddr_tg_pkg::SEQ_WRITE: begin
          if (word_done) begin
            cmd_done_q  <= 1'b0;
            data_done_q <= 1'b0;
            if (last_word) begin
              // Rewind for the read pass
              state_q <= ddr_tg_pkg::SEQ_READ;
              addr_q  <= cfg_i.base_addr;
              rem_q   <= cfg_i.words;
            end else begin
              addr_q <= addr_q + ddr_tg_pkg::ADDR_STEP;
              rem_q  <= rem_q - 16'd1;
            end
          end else begin
            if (cmd_acc) begin
              cmd_done_q <= 1'b1;
            end
            if (data_acc) begin
              data_done_q <= 1'b1;
            end
          end
        end

        ddr_tg_pkg::SEQ_READ: begin
          if (cmd_acc) begin
            if (last_word) begin
              state_q <= ddr_tg_pkg::SEQ_IDLE;
            end else begin
              addr_q <= addr_q + ddr_tg_pkg::ADDR_STEP;
              rem_q  <= rem_q - 16'd1;
            end
          end
        end

        default: state_q <= ddr_tg_pkg::SEQ_IDLE;
      endcase
    end
  end

  // The controller may sample the request any time before it raises ready
  a_req_stable : assert property (
    @(posedge c0_ddr4_clk) disable iff (!arst_n_i)
    (app_en_o && !app_rdy_i) |=> $stable(app_req_o)
  );

endmodule

`default_nettype wire

/* src/ddr_tg_regs.sv */
// Configuration and status registers of the DDR4 traffic tester.
// A CTRL write with bit 0 set issues one start pulse once calibration is
// done and no test is running; status fields read back with no latency.

`timescale 1ns/10ps
`default_nettype none

module ddr_tg_regs (
  input  wire                     c0_ddr4_clk,
  input  wire                     arst_n_i,
  input  wire                     calib_complete_i,
  input  wire                     reg_we_i,
  input  wire [2:0]               reg_addr_i,
  input  wire [31:0]              reg_wdata_i,
  output logic [31:0]             reg_rdata_o,
  input  ddr_tg_pkg::tg_status_t  status_i,
  output ddr_tg_pkg::tg_cfg_t     cfg_o,
  output logic                    start_o
);

  localparam logic [2:0] REG_CTRL      = 3'd0;
  localparam logic [2:0] REG_BASE      = 3'd1;
  localparam logic [2:0] REG_WORDS     = 3'd2;
  localparam logic [2:0] REG_STATUS    = 3'd3;
  localparam logic [2:0] REG_ERR_CNT   = 3'd4;
  localparam logic [2:0] REG_FIRST_ERR = 3'd5;

  ddr_tg_pkg::tg_cfg_t cfg_q;
  logic                cfg_lock;
  logic                ctrl_wr;

  // Config is frozen from the start pulse until the run completes
  assign cfg_lock = status_i.running | start_o;
  assign ctrl_wr  = reg_we_i && (reg_addr_i == REG_CTRL);

  // ************************************************************************
  // Configuration registers
  // ************************************************************************
  always_ff @(posedge c0_ddr4_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q <= '0;
    end else if (reg_we_i && !cfg_lock) begin
      case (reg_addr_i)
        REG_CTRL:  cfg_q.pattern   <= ddr_tg_pkg::pattern_e'(reg_wdata_i[2:1]);
        REG_BASE:  cfg_q.base_addr <= reg_wdata_i[ddr_tg_pkg::APP_ADDR_W-1:0];
        REG_WORDS: cfg_q.words     <= reg_wdata_i[15:0];
        default:   cfg_q           <= cfg_q;
      endcase
    end
  end

  assign cfg_o = cfg_q;

  // Start pulse, one cycle after the CTRL write
  always_ff @(posedge c0_ddr4_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      start_o <= 1'b0;
    end else begin
      start_o <= ctrl_wr && reg_wdata_i[0] && calib_complete_i && !cfg_lock;
    end
  end

  // ************************************************************************
  // Read back
  // ************************************************************************
  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      REG_CTRL:      reg_rdata_o[2:1] = cfg_q.pattern;
      REG_BASE:      reg_rdata_o[ddr_tg_pkg::APP_ADDR_W-1:0] = cfg_q.base_addr;
      REG_WORDS:     reg_rdata_o[15:0] = cfg_q.words;
      REG_STATUS:    reg_rdata_o[1:0] = {status_i.done, status_i.running};
      REG_ERR_CNT:   reg_rdata_o[15:0] = status_i.err_cnt;
      REG_FIRST_ERR: reg_rdata_o[ddr_tg_pkg::APP_ADDR_W-1:0] = status_i.first_err_addr;
      default:       reg_rdata_o = '0;
    endcase
  end

  // A start pulse never lands in a run that is still going
  a_start_not_running : assert property (
    @(posedge c0_ddr4_clk) disable iff (!arst_n_i)
    start_o |-> !status_i.running
  );

endmodule

`default_nettype wire

/* src/ddr_tg_pkg.sv */
// Shared widths, enums, structs and the data pattern rule for the DDR4
// traffic tester. Every tester module refers to these by scoped names.

`default_nettype none

package ddr_tg_pkg;

  // Application interface address width and per-word address increment
  localparam int unsigned APP_ADDR_W = 28;
  localparam logic [APP_ADDR_W-1:0] ADDR_STEP = 28'd8;

  // One pattern lane; the data word is this lane repeated
  localparam int unsigned LANE_W = 64;

  // Controller command encoding
  typedef enum logic [2:0] {
    APP_CMD_WRITE = 3'd0,
    APP_CMD_READ  = 3'd1
  } app_cmd_e;

  typedef enum logic [1:0] {
    PAT_ADDR     = 2'd0,
    PAT_INV_ADDR = 2'd1,
    PAT_CHECKER  = 2'd2,
    PAT_WALK1    = 2'd3
  } pattern_e;

  typedef enum logic [1:0] {
    SEQ_IDLE  = 2'd0,
    SEQ_WRITE = 2'd1,
    SEQ_READ  = 2'd2
  } seq_state_e;

  typedef struct packed {
    logic [APP_ADDR_W-1:0] base_addr;
    logic [15:0]           words;
    pattern_e              pattern;
  } tg_cfg_t;

  typedef struct packed {
    logic                  running;
    logic                  done;
    logic [15:0]           err_cnt;
    logic [APP_ADDR_W-1:0] first_err_addr;
  } tg_status_t;

  typedef struct packed {
    app_cmd_e              cmd;
    logic [APP_ADDR_W-1:0] addr;
  } app_req_t;

  // Expected lane content for a given word address
  function automatic logic [LANE_W-1:0] pattern_lane(input logic [APP_ADDR_W-1:0] addr,
                                                     input pattern_e pat);
    logic [LANE_W-1:0] lane;
    case (pat)
      PAT_ADDR:     lane = {{(LANE_W-APP_ADDR_W){1'b0}}, addr};
      PAT_INV_ADDR: lane = ~{{(LANE_W-APP_ADDR_W){1'b0}}, addr};
      PAT_CHECKER:  lane = addr[3] ? {(LANE_W/4){4'hA}} : {(LANE_W/4){4'h5}};
      // Walking one, one position per burst
      default:      lane = {{(LANE_W-1){1'b0}}, 1'b1} << addr[8:3];
    endcase
    return lane;
  endfunction

endpackage

`default_nettype wire
